// File: files.f
hdl/organPkg.sv
hdl/noteSelect.sv
hdl/toneGen.sv
hdl/displayDriver.sv
hdl/organTop.sv
tb/organTb.sv

// File: hdl/displayDriver.sv
/* Scans the red/green LED matrix one row per clock and drives the
   seven-segment digit with the current note number. */
`timescale 1ns/10ps

module displayDriver
	import organPkg::*;
(
	input  logic                  CLK,
	input  logic                  rstN,
	input  logic [ModeW-1:0]      modeSw,
	input  logic [NoteW-1:0]      noteIdx,
	input  logic                  noteOn,
	output logic [MatrixSize-1:0] rowN,
	output logic [MatrixSize-1:0] colRed,
	output logic [MatrixSize-1:0] colGreen,
	output logic [6:0]            seg
);

	logic [$clog2(MatrixSize)-1:0] rowIdx;
	logic [MatrixSize-1:0] rowSel;
	logic [MatrixSize-1:0] noteMask;
	logic [MatrixSize-1:0] cols;
	logic redEn;
	logic greenEn;
	logic [6:0] segNext;

	// modulo-8 row counter
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			rowIdx <= '0;
		end else begin
			rowIdx <= rowIdx + 1'b1;
		end
	end

	// row 0 sits on the top bit
	assign rowSel = {1'b1, {(MatrixSize - 1){1'b0}}} >> rowIdx;

	// note n owns column bit 6-n
	assign noteMask = (MatrixSize'(1) << (NumKeys - 1)) >> noteIdx;
	assign cols = noteOn ? (StairRows[rowIdx] & ~noteMask) : StairRows[rowIdx];

	// mid red, low and auto green, high both
	always_comb begin
		redEn = 1'b0;
		greenEn = 1'b0;
		case (modeSw)
			ModeMid: redEn = 1'b1;
			ModeLow, ModeAuto: greenEn = 1'b1;
			ModeHigh: begin
				redEn = 1'b1;
				greenEn = 1'b1;
			end
			default: begin
				redEn = 1'b0;
				greenEn = 1'b0;
			end
		endcase
	end

	assign segNext = (noteOn && noteIdx < NumKeys) ? SegCodes[noteIdx] : 7'b0000000;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			rowN <= '1;
			colRed <= '0;
			colGreen <= '0;
			seg <= '0;
		end else begin
			rowN <= ~rowSel;
			colRed <= redEn ? cols : '0;
			colGreen <= greenEn ? cols : '0;
			seg <= segNext;
		end
	end

endmodule

// File: hdl/noteSelect.sv
/* Picks the sounding note: a single pressed key in the manual modes,
   or the stepped melody when the switch is in auto. */
`timescale 1ns/10ps

module noteSelect
	import organPkg::*;
(
	input  logic               CLK,
	input  logic               rstN,
	input  logic [NumKeys-1:0] keys,
	input  logic [ModeW-1:0]   modeSw,
	output logic [NoteW-1:0]   noteIdx,
	output logic               noteOn
);

	logic [NoteW-1:0] keyIdx;
	logic keyValid;
	logic autoMode;
	logic beatEnd;
	logic [BeatCountW-1:0] beatCnt;
	logic [$clog2(MelodyLen)-1:0] beatIdx;

	assign autoMode = (modeSw == ModeAuto);
	assign beatEnd = (beatCnt == BeatCountW'(BeatCycles - 1));

	// key bit 6 is do, exactly one bit must be set
	always_comb begin
		keyIdx = '0;
		keyValid = 1'b0;
		for (int n = 0; n < NumKeys; n++) begin
			if (keys == (NumKeys'(1) << (NumKeys - 1 - n))) begin
				keyIdx = NoteW'(n);
				keyValid = 1'b1;
			end
		end
	end

	// beat timer and melody position, parked at zero outside auto
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			beatCnt <= '0;
			beatIdx <= '0;
		end else if (!autoMode) begin
			beatCnt <= '0;
			beatIdx <= '0;
		end else if (beatEnd) begin
			beatCnt <= '0;
			// wraps naturally after the last beat
			beatIdx <= beatIdx + 1'b1;
		end else begin
			beatCnt <= beatCnt + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			noteIdx <= '0;
			noteOn <= 1'b0;
		end else if (autoMode) begin
			noteIdx <= Melody[beatIdx];
			noteOn <= 1'b1;
		end else if (keyValid) begin
			noteIdx <= keyIdx;
			noteOn <= 1'b1;
		end else begin
			// keep last index, only silence it
			noteOn <= 1'b0;
		end
	end

endmodule

// File: hdl/organPkg.sv
/* Shared constants of the organ: widths, switch codes and the lookup tables.
   Every design module pulls what it needs in by wildcard import. */
package organPkg;

	// key and note geometry
	localparam int NumKeys = 7;
	localparam int NoteW = 3;
	localparam int ModeW = 4;
	localparam int MatrixSize = 8;

	// one-hot mode switch positions
	localparam logic [ModeW-1:0] ModeLow = 4'b0001;
	localparam logic [ModeW-1:0] ModeMid = 4'b0010;
	localparam logic [ModeW-1:0] ModeHigh = 4'b0100;
	localparam logic [ModeW-1:0] ModeAuto = 4'b1000;

	// quarter second per beat at 1 MHz
	localparam int BeatCycles = 250000;
	localparam int BeatCountW = 18;
	localparam int MelodyLen = 16;

	// half periods in clocks, do..xi
	localparam int PitchW = 11;

	localparam logic [PitchW-1:0] PitchLow [NumKeys] = '{
		11'd1911,
		11'd1703,
		11'd1517,
		11'd1432,
		11'd1276,
		11'd1136,
		11'd1012
	};

	localparam logic [PitchW-1:0] PitchMid [NumKeys] = '{
		11'd956,
		11'd851,
		11'd758,
		11'd716,
		11'd638,
		11'd568,
		11'd506
	};

	localparam logic [PitchW-1:0] PitchHigh [NumKeys] = '{
		11'd478,
		11'd426,
		11'd379,
		11'd358,
		11'd319,
		11'd284,
		11'd253
	};

	// auto tune, one note index per beat
	localparam logic [NoteW-1:0] Melody [MelodyLen] = '{
		3'd0, 3'd0, 3'd4, 3'd4,
		3'd5, 3'd5, 3'd4, 3'd4,
		3'd3, 3'd3, 3'd2, 3'd2,
		3'd1, 3'd1, 3'd0, 3'd0
	};

	// segments a..g, msb is a, digits 1..7
	localparam logic [6:0] SegCodes [NumKeys] = '{
		7'b0110000,
		7'b1101101,
		7'b1111001,
		7'b0110011,
		7'b1011011,
		7'b1011111,
		7'b1110000
	};

	// staircase, row r lights r columns from bit 6 downwards
	localparam logic [MatrixSize-1:0] StairRows [MatrixSize] = '{
		8'b0000_0000,
		8'b0100_0000,
		8'b0110_0000,
		8'b0111_0000,
		8'b0111_1000,
		8'b0111_1100,
		8'b0111_1110,
		8'b0111_1111
	};

endpackage

// File: hdl/organTop.sv
/* Top level of the organ board design. Connects note selection,
   the buzzer divider and the display scan. */
`timescale 1ns/10ps

module organTop
	import organPkg::*;
(
	input  logic                  CLK,
	input  logic                  rstN,
	input  logic [NumKeys-1:0]    keys,
	input  logic [ModeW-1:0]      modeSw,
	output logic                  beep,
	output logic [MatrixSize-1:0] rowN,
	output logic [MatrixSize-1:0] colRed,
	output logic [MatrixSize-1:0] colGreen,
	output logic [6:0]            seg
);

	// current note shared by sound and display
	logic [NoteW-1:0] noteIdx;
	logic noteOn;

	noteSelect noteSelect_i (
		.CLK     (CLK),
		.rstN    (rstN),
		.keys    (keys),
		.modeSw  (modeSw),
		.noteIdx (noteIdx),
		.noteOn  (noteOn)
	);

	toneGen toneGen_i (
		.CLK     (CLK),
		.rstN    (rstN),
		.modeSw  (modeSw),
		.noteIdx (noteIdx),
		.noteOn  (noteOn),
		.beep    (beep)
	);

	displayDriver displayDriver_i (
		.CLK      (CLK),
		.rstN     (rstN),
		.modeSw   (modeSw),
		.noteIdx  (noteIdx),
		.noteOn   (noteOn),
		.rowN     (rowN),
		.colRed   (colRed),
		.colGreen (colGreen),
		.seg      (seg)
	);

endmodule

// File: hdl/toneGen.sv
/* Square-wave buzzer driver. Divides the clock by the half period
   of the current note in the selected octave. */
`timescale 1ns/10ps

module toneGen
	import organPkg::*;
(
	input  logic             CLK,
	input  logic             rstN,
	input  logic [ModeW-1:0] modeSw,
	input  logic [NoteW-1:0] noteIdx,
	input  logic             noteOn,
	output logic             beep
);

	logic [PitchW-1:0] halfPeriod;
	logic modeValid;
	logic active;
	logic changed;
	logic [PitchW-1:0] cnt;
	logic [NoteW-1:0] lastNote;
	logic [ModeW-1:0] lastMode;

	// octave table lookup, auto plays from the low octave
	always_comb begin
		halfPeriod = '0;
		modeValid = 1'b0;
		if (noteIdx < NumKeys) begin
			case (modeSw)
				ModeLow, ModeAuto: begin
					halfPeriod = PitchLow[noteIdx];
					modeValid = 1'b1;
				end
				ModeMid: begin
					halfPeriod = PitchMid[noteIdx];
					modeValid = 1'b1;
				end
				ModeHigh: begin
					halfPeriod = PitchHigh[noteIdx];
					modeValid = 1'b1;
				end
				default: modeValid = 1'b0;
			endcase
		end
	end

	assign active = noteOn && modeValid;
	assign changed = (noteIdx != lastNote) || (modeSw != lastMode);

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			cnt <= '0;
			beep <= 1'b0;
			lastNote <= '0;
			lastMode <= '0;
		end else begin
			lastNote <= noteIdx;
			lastMode <= modeSw;
			if (!active) begin
				cnt <= '0;
				beep <= 1'b0;
			end else if (changed) begin
				// restart the period on a new pitch
				cnt <= '0;
			end else if (cnt == halfPeriod) begin
				cnt <= '0;
				beep <= ~beep;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# build the organ testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module organTb -f files.f -o organSim \
	&& ./obj_dir/organSim \
	|| exit 1

// File: tb/organTb.sv
/* Directed testbench for the organ top level. Checks reset values, the matrix
   scan, buzzer pitch, the digit and the auto melody. */
`timescale 1ns/10ps

module organTb
	import organPkg::*;
();

	logic CLK;
	logic rstN;
	logic [NumKeys-1:0] keys;
	logic [ModeW-1:0] modeSw;
	logic beep;
	logic [MatrixSize-1:0] rowN;
	logic [MatrixSize-1:0] colRed;
	logic [MatrixSize-1:0] colGreen;
	logic [6:0] seg;
	logic [31:0] rngState;

	organTop organTop_i (
		.CLK      (CLK),
		.rstN     (rstN),
		.keys     (keys),
		.modeSw   (modeSw),
		.beep     (beep),
		.rowN     (rowN),
		.colRed   (colRed),
		.colGreen (colGreen),
		.seg      (seg)
	);

	// 20 ns clock
	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function logic [31:0] nextRandom();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	// note n is key bit 6-n
	function automatic logic [NumKeys-1:0] keyFor(input int n);
		return 7'b100_0000 >> n;
	endfunction

	// {red, green} enables for each mode
	function automatic logic [1:0] colourRule(input logic [ModeW-1:0] m);
		case (m)
			ModeMid: return 2'b10;
			ModeLow, ModeAuto: return 2'b01;
			ModeHigh: return 2'b11;
			default: return 2'b00;
		endcase
	endfunction

	function automatic int halfPeriodFor(input logic [ModeW-1:0] m, input int n);
		case (m)
			ModeMid: return int'(PitchMid[n]);
			ModeHigh: return int'(PitchHigh[n]);
			default: return int'(PitchLow[n]);
		endcase
	endfunction

	task automatic stopRun();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic drive(input logic [NumKeys-1:0] k, input logic [ModeW-1:0] m);
		@(posedge CLK);
		keys <= k;
		modeSw <= m;
	endtask

	task automatic waitClocks(input int n);
		repeat (n) @(negedge CLK);
	endtask

	task automatic waitBeepToggle(input int limit, output int clocks);
		logic prev;
		prev = beep;
		clocks = 0;
		do begin
			@(negedge CLK);
			clocks++;
		end while (beep == prev && clocks < limit);
		if (beep == prev) begin
			$display("timeout: buzzer did not toggle within %0d clocks", limit);
			stopRun();
		end
	endtask

	task automatic waitSegChange(input int limit, output int clocks);
		logic [6:0] prev;
		prev = seg;
		clocks = 0;
		do begin
			@(negedge CLK);
			clocks++;
		end while (seg == prev && clocks < limit);
		if (seg == prev) begin
			$display("timeout: digit did not change within %0d clocks", limit);
			stopRun();
		end
	endtask

	// toggles sit half period + 1 apart
	// spent counts every clock used
	task automatic measurePitch(input logic [ModeW-1:0] m, input int n, output int spent);
		int first;
		int period;
		waitClocks(3);
		waitBeepToggle(4000, first);
		waitBeepToggle(4000, period);
		check("beep half period", 32'(period), 32'(halfPeriodFor(m, n) + 1));
		spent = 3 + first + period;
	endtask

	task automatic expectSilence(input int clocks);
		for (int i = 0; i < clocks; i++) begin
			@(negedge CLK);
			check("beep", 32'(beep), 32'd0);
		end
	endtask

	task automatic resetValues();
		repeat (7) @(posedge CLK);
		@(negedge CLK);
		check("beep", 32'(beep), 32'd0);
		check("colRed", 32'(colRed), 32'd0);
		check("colGreen", 32'(colGreen), 32'd0);
		check("seg", 32'(seg), 32'd0);
		check("rowN", 32'(rowN), 32'hff);
		@(posedge CLK);
		rstN <= 1'b1;
		// first scanned row is row 0 on the top bit
		waitClocks(2);
		check("rowN", 32'(rowN), 32'h7f);
	endtask

	task automatic matrixScan();
		logic [ModeW-1:0] modes [6];
		logic [MatrixSize-1:0] seen;
		logic [MatrixSize-1:0] mask;
		logic [MatrixSize-1:0] expCols;
		logic [1:0] colours;
		int n;
		int note;
		int r;
		int zeros;
		modes = '{ModeLow, ModeMid, ModeHigh, ModeAuto, 4'b0110, ModeHigh};
		for (int m = 0; m < 6; m++) begin
			n = int'(nextRandom() % NumKeys);
			// the last pass holds no key so no column is blanked
			drive((m == 5) ? NumKeys'(0) : keyFor(n), modes[m]);
			waitClocks(3);
			// auto ignores keys and starts on the first melody note
			note = (modes[m] == ModeAuto) ? int'(Melody[0]) : n;
			mask = (m == 5) ? 8'h00 : 8'b0100_0000 >> note;
			colours = colourRule(modes[m]);
			seen = '0;
			for (int c = 0; c < MatrixSize; c++) begin
				@(negedge CLK);
				zeros = 0;
				r = 0;
				for (int b = 0; b < MatrixSize; b++) begin
					if (!rowN[b]) begin
						zeros++;
						r = MatrixSize - 1 - b;
					end
				end
				check("rowN low bit count", 32'(zeros), 32'd1);
				seen[r] = 1'b1;
				expCols = StairRows[r] & ~mask;
				check("colRed", 32'(colRed), colours[1] ? 32'(expCols) : 32'd0);
				check("colGreen", 32'(colGreen), colours[0] ? 32'(expCols) : 32'd0);
			end
			check("rows visited", 32'(seen), 32'hff);
		end
	endtask

	task automatic buzzerPitch();
		logic [ModeW-1:0] octaves [3];
		logic [ModeW-1:0] m;
		int n;
		int spent;
		octaves = '{ModeLow, ModeMid, ModeHigh};
		for (int i = 0; i < 8; i++) begin
			n = int'(nextRandom() % NumKeys);
			m = octaves[int'(nextRandom() % 3)];
			drive(keyFor(n), m);
			measurePitch(m, n, spent);
		end
		// no key and then two keys at once
		drive('0, ModeLow);
		waitClocks(3);
		expectSilence(3000);
		drive(7'b101_0000, ModeMid);
		waitClocks(3);
		expectSilence(3000);
	endtask

	task automatic digitDisplay();
		for (int n = 0; n < NumKeys; n++) begin
			drive(keyFor(n), ModeMid);
			waitClocks(3);
			check("seg", 32'(seg), 32'(SegCodes[n]));
		end
		drive('0, ModeMid);
		waitClocks(3);
		check("seg", 32'(seg), 32'd0);
	endtask

	task automatic autoMelody();
		int clocks;
		int spent;
		int elapsed;
		int cur;
		int nb;
		drive('0, ModeLow);
		waitClocks(3);
		check("seg", 32'(seg), 32'd0);
		drive('0, ModeAuto);
		// note register then digit register give the third falling edge
		waitSegChange(10, clocks);
		check("first note latency", 32'(clocks), 32'd3);
		check("seg", 32'(seg), 32'(SegCodes[Melody[0]]));
		cur = 0;
		measurePitch(ModeAuto, int'(Melody[0]), elapsed);
		while (cur < 4) begin
			// repeated notes leave the digit unchanged
			nb = cur + 1;
			while (nb < MelodyLen - 1 && Melody[nb] == Melody[cur]) begin
				nb++;
			end
			waitSegChange(3 * BeatCycles, clocks);
			elapsed += clocks;
			check("note spacing", 32'(elapsed), 32'((nb - cur) * BeatCycles));
			check("seg", 32'(seg), 32'(SegCodes[Melody[nb]]));
			cur = nb;
			measurePitch(ModeAuto, int'(Melody[cur]), spent);
			elapsed = spent;
		end
	endtask

	initial begin
		rngState = 32'he086;
		rstN <= 1'b0;
		keys <= '0;
		modeSw <= ModeLow;
		resetValues();
		matrixScan();
		buzzerPitch();
		digitDisplay();
		autoMelody();
		$display("All tests passed");
		$finish;
	end

endmodule
